/* src/radio_pkg.sv */
`default_nettype none

package radio_pkg;

   //////////////////////////////////////////////////
   // Sample and stream types
   //////////////////////////////////////////////////

   // One I or Q component, two's complement
   typedef logic signed [15:0] iq_comp_t;

   // Complex sample, I in 31:16 and Q in 15:0
   typedef logic [31:0] sample_t;

   // Crossbar word, two samples per word
   typedef logic [63:0] stream_word_t;

   //////////////////////////////////////////////////
   // Settings bus
   //////////////////////////////////////////////////

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // Single-cycle write, valid while stb is high
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } setting_bus_t;

   //////////////////////////////////////////////////
   // Front-end configuration
   //////////////////////////////////////////////////

   typedef struct packed {
      iq_comp_t offset_i;   // DC offset removed from I
      iq_comp_t offset_q;   // DC offset removed from Q
      logic     swap_iq;    // Exchange I and Q before anything else
      logic     invert_q;   // Negate Q after the swap
   } fe_config_t;

   //////////////////////////////////////////////////
   // Settings addresses
   //////////////////////////////////////////////////

   localparam int SET_RX_FE_BASE = 232;

   // Base+0 and base+1 hold magnitude and phase correction, not decoded here
   localparam set_addr_t SR_OFFSET_I   = set_addr_t'(SET_RX_FE_BASE + 2);
   localparam set_addr_t SR_OFFSET_Q   = set_addr_t'(SET_RX_FE_BASE + 3);
   localparam set_addr_t SR_IQ_MAPPING = set_addr_t'(SET_RX_FE_BASE + 4);

   // Bit positions inside the mapping register
   localparam int MAP_SWAP_BIT   = 0;
   localparam int MAP_INVERT_BIT = 1;

endpackage : radio_pkg

`default_nettype wire

/* src/rx_settings_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module rx_settings_regs (
   input  wire                      radio_clk,
   input  wire                      rst_n_i,
   input  wire radio_pkg::setting_bus_t set_bus_i,   // One write per strobe
   output radio_pkg::fe_config_t    config_o
);

   import radio_pkg::*;

   //////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////

   logic hit_offset_i;
   logic hit_offset_q;
   logic hit_mapping;

   // Only strobed cycles count
   assign hit_offset_i = set_bus_i.stb && (set_bus_i.addr == SR_OFFSET_I);
   assign hit_offset_q = set_bus_i.stb && (set_bus_i.addr == SR_OFFSET_Q);
   assign hit_mapping  = set_bus_i.stb && (set_bus_i.addr == SR_IQ_MAPPING);

   //////////////////////////////////////////////////
   // Configuration registers
   //////////////////////////////////////////////////

   // New value visible the cycle after the write
   always_ff @(posedge radio_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         config_o <= '0;                   // No offset, straight mapping
      end else begin
         if (hit_offset_i) begin
            config_o.offset_i <= iq_comp_t'(set_bus_i.data[15:0]);
         end
         if (hit_offset_q) begin
            config_o.offset_q <= iq_comp_t'(set_bus_i.data[15:0]);
         end
         if (hit_mapping) begin
            config_o.swap_iq  <= set_bus_i.data[MAP_SWAP_BIT];
            config_o.invert_q <= set_bus_i.data[MAP_INVERT_BIT];
         end
      end
   end

   // Magnitude, phase and anything outside
   // the front-end window simply fall through

endmodule : rx_settings_regs

`default_nettype wire

/* src/rx_frontend.sv */
`timescale 1ns/10ps
`default_nettype none

module rx_frontend (
   input  wire                     radio_clk,
   input  wire                     rst_n_i,
   input  wire radio_pkg::fe_config_t config_i,
   input  wire                     adc_stb_i,
   input  wire radio_pkg::sample_t adc_data_i,
   output logic                    rx_stb_o,
   output radio_pkg::sample_t      rx_data_o
);

   import radio_pkg::*;

   //////////////////////////////////////////////////
   // Saturating helpers
   //////////////////////////////////////////////////

   // a - b clamped to the 16-bit signed range
   function automatic iq_comp_t sub_sat(input iq_comp_t a, input iq_comp_t b);
      logic [16:0] diff;
      diff = {a[15], a} - {b[15], b};
      case (diff[16:15])
         2'b01:   return 16'sh7fff;        // Positive overflow
         2'b10:   return 16'sh8000;        // Negative overflow
         default: return iq_comp_t'(diff[15:0]);
      endcase
   endfunction

   // Negation, the one unrepresentable case maps to full scale
   function automatic iq_comp_t neg_sat(input iq_comp_t a);
      if (a == 16'sh8000) begin
         return 16'sh7fff;
      end
      return iq_comp_t'(~a + 16'd1);
   endfunction

   //////////////////////////////////////////////////
   // Mapping and DC offset
   //////////////////////////////////////////////////

   iq_comp_t raw_i, raw_q;
   iq_comp_t swp_i, swp_q;
   iq_comp_t map_q;
   iq_comp_t corr_i, corr_q;

   always_comb begin
      raw_i = iq_comp_t'(adc_data_i[31:16]);
      raw_q = iq_comp_t'(adc_data_i[15:0]);

      // Swap first, invert acts on the post-swap Q
      swp_i = config_i.swap_iq ? raw_q : raw_i;
      swp_q = config_i.swap_iq ? raw_i : raw_q;
      map_q = config_i.invert_q ? neg_sat(swp_q) : swp_q;

      corr_i = sub_sat(swp_i, config_i.offset_i);
      corr_q = sub_sat(map_q, config_i.offset_q);
   end

   //////////////////////////////////////////////////
   // Output register
   //////////////////////////////////////////////////

   always_ff @(posedge radio_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rx_stb_o <= 1'b0;
      end else begin
         rx_stb_o <= adc_stb_i;              // Strobe follows data by one stage
      end
   end

   always_ff @(posedge radio_clk) begin
      if (adc_stb_i) begin
         rx_data_o <= {corr_i, corr_q};
      end
   end

endmodule : rx_frontend

`default_nettype wire

/* src/sample_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_fifo #(
   parameter int FIFO_DEPTH_LOG2 = 4
) (
   input  wire                     radio_clk,
   input  wire                     rst_n_i,
   // Push side, no back-pressure
   input  wire                     wr_stb_i,
   input  wire radio_pkg::sample_t wr_data_i,
   // Pop side
   output logic                    rd_valid_o,
   output radio_pkg::sample_t      rd_data_o,
   input  wire                     rd_ready_i,
   output logic                    overflow_o
);

   import radio_pkg::*;

   localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

   typedef logic [FIFO_DEPTH_LOG2-1:0] ptr_t;
   typedef logic [FIFO_DEPTH_LOG2:0]   count_t;   // One extra bit for the full case

   sample_t mem [DEPTH];
   ptr_t    wr_ptr;
   ptr_t    rd_ptr;
   count_t  count;
   logic    full;
   logic    do_wr;
   logic    do_rd;

   //////////////////////////////////////////////////
   // Status
   //////////////////////////////////////////////////

   assign full       = (count == count_t'(DEPTH));
   assign rd_valid_o = (count != '0);
   assign do_wr      = wr_stb_i && !full;     // Drop when full
   assign do_rd      = rd_valid_o && rd_ready_i;
   assign rd_data_o  = mem[rd_ptr];           // Head of queue always shown

   //////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   //////////////////////////////////////////////////
   // Pointers, count and overflow
   //////////////////////////////////////////////////

   always_ff @(posedge radio_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         overflow_o <= 1'b0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + ptr_t'(1);   // Wraps at depth
         if (do_rd) rd_ptr <= rd_ptr + ptr_t'(1);

         case ({do_wr, do_rd})
            2'b10:   count <= count + count_t'(1);
            2'b01:   count <= count - count_t'(1);
            default: count <= count;
         endcase

         // Sticky until reset
         if (wr_stb_i && full) begin
            overflow_o <= 1'b1;
         end
      end
   end

endmodule : sample_fifo

`default_nettype wire

/* src/rx_packetizer.sv */
`timescale 1ns/10ps
`default_nettype none

module rx_packetizer #(
   parameter int SAMPLES_PER_PKT = 8   // Must be even
) (
   input  wire                      radio_clk,
   input  wire                      rst_n_i,
   input  wire                      s_valid_i,
   input  wire radio_pkg::sample_t  s_data_i,
   output logic                     s_ready_o,
   output radio_pkg::stream_word_t  tdata_o,
   output logic                     tlast_o,
   output logic                     tvalid_o,
   input  wire                      tready_i
);

   import radio_pkg::*;

   localparam int WORDS_PER_PKT = SAMPLES_PER_PKT / 2;
   localparam int CNT_W = (WORDS_PER_PKT > 1) ? $clog2(WORDS_PER_PKT) : 1;

   typedef enum logic [1:0] {
      TAKE_HI,     // Earlier sample, goes to 63:32
      TAKE_LO,
      PRESENT      // Word on the bus, waiting for tready
   } pkt_state_t;

   typedef logic [CNT_W-1:0] word_cnt_t;

   pkt_state_t state;
   word_cnt_t  word_cnt;
   sample_t    hi_q;
   sample_t    lo_q;
   logic       take;
   logic       word_done;
   logic       last_word;

   assign s_ready_o = (state != PRESENT);
   assign take      = s_valid_i && s_ready_o;
   assign tvalid_o  = (state == PRESENT);
   assign word_done = tvalid_o && tready_i;
   assign last_word = (word_cnt == word_cnt_t'(WORDS_PER_PKT - 1));
   assign tlast_o   = tvalid_o && last_word;
   assign tdata_o   = {hi_q, lo_q};

   //////////////////////////////////////////////////
   // FSM and word counter
   //////////////////////////////////////////////////

   always_ff @(posedge radio_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state    <= TAKE_HI;
         word_cnt <= '0;
      end else begin
         case (state)
            TAKE_HI: if (take)      state <= TAKE_LO;
            TAKE_LO: if (take)      state <= PRESENT;
            PRESENT: if (word_done) state <= TAKE_HI;
            default:                state <= TAKE_HI;
         endcase

         if (word_done) begin
            word_cnt <= last_word ? '0 : word_cnt + word_cnt_t'(1);   // Wrap per packet
         end
      end
   end

   // Payload only moves in take states, so it holds while stalled
   always_ff @(posedge radio_clk) begin
      if (take && state == TAKE_HI) hi_q <= s_data_i;
      if (take && state == TAKE_LO) lo_q <= s_data_i;
   end

endmodule : rx_packetizer

`default_nettype wire

/* src/rx_radio_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rx_radio_top #(
   parameter int SAMPLES_PER_PKT = 8,
   parameter int FIFO_DEPTH_LOG2 = 4
) (
   input  wire                        radio_clk,
   input  wire                        rst_n_i,
   // Settings writes
   input  wire radio_pkg::setting_bus_t set_bus_i,
   // Raw ADC samples
   input  wire                        adc_stb_i,
   input  wire radio_pkg::sample_t    adc_data_i,
   // Stream toward the crossbar
   output radio_pkg::stream_word_t    tdata_o,
   output logic                       tlast_o,
   output logic                       tvalid_o,
   input  wire                        tready_i,
   output logic                       overflow_o
);

   import radio_pkg::*;

   fe_config_t fe_config;
   logic       fe_stb;        // Corrected sample strobe
   sample_t    fe_data;
   logic       buf_valid;
   sample_t    buf_data;
   logic       buf_ready;

   //////////////////////////////////////////////////
   // Control path
   //////////////////////////////////////////////////

   rx_settings_regs rx_settings_regs_inst (
      .radio_clk (radio_clk),
      .rst_n_i   (rst_n_i),
      .set_bus_i (set_bus_i),
      .config_o  (fe_config)
   );

   //////////////////////////////////////////////////
   // Sample path
   //////////////////////////////////////////////////

   rx_frontend rx_frontend_inst (
      .radio_clk  (radio_clk),
      .rst_n_i    (rst_n_i),
      .config_i   (fe_config),
      .adc_stb_i  (adc_stb_i),
      .adc_data_i (adc_data_i),
      .rx_stb_o   (fe_stb),
      .rx_data_o  (fe_data)
   );

   sample_fifo #(
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) sample_fifo_inst (
      .radio_clk  (radio_clk),
      .rst_n_i    (rst_n_i),
      .wr_stb_i   (fe_stb),
      .wr_data_i  (fe_data),
      .rd_valid_o (buf_valid),
      .rd_data_o  (buf_data),
      .rd_ready_i (buf_ready),
      .overflow_o (overflow_o)
   );

   rx_packetizer #(
      .SAMPLES_PER_PKT (SAMPLES_PER_PKT)
   ) rx_packetizer_inst (
      .radio_clk (radio_clk),
      .rst_n_i   (rst_n_i),
      .s_valid_i (buf_valid),
      .s_data_i  (buf_data),
      .s_ready_o (buf_ready),
      .tdata_o   (tdata_o),
      .tlast_o   (tlast_o),
      .tvalid_o  (tvalid_o),
      .tready_i  (tready_i)
   );

endmodule : rx_radio_top

`default_nettype wire

/* testbench/tb_rx_radio_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rx_radio_asserts (
   input wire                          radio_clk,
   input wire                          rst_n_i,
   input wire radio_pkg::stream_word_t tdata_i,
   input wire                          tlast_i,
   input wire                          tvalid_i,
   input wire                          tready_i,
   input wire                          overflow_i
);

   //////////////////////////////////////////////////
   // Stream handshake
   //////////////////////////////////////////////////

   // A stalled word keeps its payload
   property word_held_while_stalled;
      @(posedge radio_clk) disable iff (!rst_n_i)
         (tvalid_i && !tready_i) |=> (tvalid_i && $stable(tdata_i) && $stable(tlast_i));
   endproperty

   hold_check: assert property (word_held_while_stalled)
      else $error("Stream word dropped or changed while tready was low");

   reset_check: assert property (@(posedge radio_clk) !rst_n_i |-> !tvalid_i)
      else $error("tvalid high during reset");

   //////////////////////////////////////////////////
   // Overflow flag
   //////////////////////////////////////////////////

   sticky_check: assert property (@(posedge radio_clk) disable iff (!rst_n_i) !$fell(overflow_i))
      else $error("overflow cleared without a reset");

endmodule : tb_rx_radio_asserts

bind rx_radio_top tb_rx_radio_asserts tb_rx_radio_asserts_inst (
   .radio_clk  (radio_clk),
   .rst_n_i    (rst_n_i),
   .tdata_i    (tdata_o),
   .tlast_i    (tlast_o),
   .tvalid_i   (tvalid_o),
   .tready_i   (tready_i),
   .overflow_i (overflow_o)
);

`default_nettype wire

/* testbench/tb_rx_radio.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rx_radio;

   import radio_pkg::*;

   localparam int SAMPLES_PER_PKT = 8;
   localparam int FIFO_DEPTH_LOG2 = 4;
   localparam int DEPTH           = 1 << FIFO_DEPTH_LOG2;
   localparam int WORDS_PER_PKT   = SAMPLES_PER_PKT / 2;
   localparam int CLK_PERIOD      = 4;
   localparam int RESET_CYCLES    = 8;
   localparam int P1_N = 64;          // Raw pairs
   localparam int P2_N = 64;          // DC offset
   localparam int P3_N = 16;          // Per mapping value
   localparam int P5_N = 96;          // Random back-pressure
   localparam int P6_N = DEPTH + 8;   // Drops an even number in the overflow test
   localparam int TOTAL_SAMPLES  = P1_N + P2_N + 4 * P3_N + P5_N + P6_N;
   // One word held in the stalled packetizer plus a full FIFO
   localparam int OVF_WORDS      = (DEPTH + 2) / 2;
   localparam int EXPECTED_WORDS = (P1_N + P2_N + 4 * P3_N + P5_N) / 2 + OVF_WORDS;

   logic         radio_clk;
   logic         rst_n_i;
   setting_bus_t set_bus_i;
   logic         adc_stb_i;
   sample_t      adc_data_i;
   logic         tready_i;
   stream_word_t tdata_o;
   logic         tlast_o;
   logic         tvalid_o;
   logic         overflow_o;

   // Model of the active configuration
   int          cfg_off_i;
   int          cfg_off_q;
   bit          cfg_swap;
   bit          cfg_inv;
   sample_t     exp_q[$];
   int          word_count;
   bit          lossy;           // Output is only a subsequence during overflow
   bit          toggle_ready;
   bit          verdict_done;
   logic [31:0] lfsr = 32'hc8233724;

   rx_radio_top #(
      .SAMPLES_PER_PKT (SAMPLES_PER_PKT),
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) rx_radio_top_inst (
      .radio_clk  (radio_clk),
      .rst_n_i    (rst_n_i),
      .set_bus_i  (set_bus_i),
      .adc_stb_i  (adc_stb_i),
      .adc_data_i (adc_data_i),
      .tdata_o    (tdata_o),
      .tlast_o    (tlast_o),
      .tvalid_o   (tvalid_o),
      .tready_i   (tready_i),
      .overflow_o (overflow_o)
   );

   initial begin
      radio_clk = 1'b0;
      forever #(CLK_PERIOD / 2) radio_clk = ~radio_clk;
   end

   //////////////////////////////////////////////////
   // Random numbers and reference model
   //////////////////////////////////////////////////

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int k = 0; k < n; k++) begin
         val  = {val[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return val;
   endfunction

   function automatic logic [15:0] rand_component(input bit extremes);
      logic [1:0] pick;
      if (extremes) begin
         pick = 2'(rand_bits(2));
         if (pick == 2'd0) return 16'h8000;   // Full scale negative
         if (pick == 2'd1) return 16'h7fff;
      end
      return 16'(rand_bits(16));
   endfunction

   function automatic int clamp16(input int v);
      if (v > 32767) return 32767;
      if (v < -32768) return -32768;
      return v;
   endfunction

   function automatic sample_t model_sample(input sample_t raw);
      int i_val;
      int q_val;
      int tmp;
      i_val = int'($signed(raw[31:16]));
      q_val = int'($signed(raw[15:0]));
      if (cfg_swap) begin
         tmp   = i_val;
         i_val = q_val;
         q_val = tmp;
      end
      if (cfg_inv) q_val = clamp16(-q_val);   // -32768 has no positive twin
      i_val = clamp16(i_val - cfg_off_i);
      q_val = clamp16(q_val - cfg_off_q);
      return {i_val[15:0], q_val[15:0]};
   endfunction

   //////////////////////////////////////////////////
   // Failure reporting
   //////////////////////////////////////////////////

   task automatic stop_with_failure(input string what);
      verdict_done = 1'b1;
      $display("%s", what);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] got);
      stop_with_failure($sformatf("Fail %s expected %h received %h", name, expected, got));
   endtask

   final begin
      if (!verdict_done) $display("RESULT: FAIL");
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   task automatic next_cycle();
      @(posedge radio_clk);
      #1;
      adc_stb_i = 1'b0;
      set_bus_i = '0;
      if (toggle_ready) tready_i = (rand_bits(1) != 32'd0);
   endtask

   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      next_cycle();
      set_bus_i.stb  = 1'b1;
      set_bus_i.addr = addr;
      set_bus_i.data = data;
   endtask

   task automatic push_sample(input sample_t raw);
      next_cycle();
      adc_stb_i  = 1'b1;
      adc_data_i = raw;
      exp_q.push_back(model_sample(raw));
   endtask

   task automatic run_samples(input int count, input bit extremes, input bit limit_pending);
      logic [15:0] i_bits;
      logic [15:0] q_bits;
      for (int n = 0; n < count; n++) begin
         if (rand_bits(1) != 32'd0) next_cycle();   // Random gap
         if (limit_pending) begin
            while (exp_q.size() >= DEPTH) next_cycle();
         end
         i_bits = rand_component(extremes);
         q_bits = rand_component(extremes);
         push_sample({i_bits, q_bits});
      end
   endtask

   task automatic drain();
      while (exp_q.size() != 0) next_cycle();
      next_cycle();
   endtask

   //////////////////////////////////////////////////
   // Output monitor
   //////////////////////////////////////////////////

   // Skips whole expected pairs until one equals the word
   task automatic match_in_order(input stream_word_t got);
      while (exp_q.size() >= 2 && {exp_q[0], exp_q[1]} != got) begin
         void'(exp_q.pop_front());
         void'(exp_q.pop_front());
      end
      assert (exp_q.size() >= 2)
         else stop_with_failure("Output word is no expected pair or came out of order");
      void'(exp_q.pop_front());
      void'(exp_q.pop_front());
   endtask

   // A word moves when valid and ready are both high
   always @(negedge radio_clk) begin
      stream_word_t expected;
      logic         exp_last;
      if (rst_n_i && tvalid_o && tready_i) begin
         if (lossy) begin
            match_in_order(tdata_o);
         end else begin
            assert (exp_q.size() >= 2)
               else stop_with_failure("Output word arrived with no expected samples pending");
            expected = {exp_q[0], exp_q[1]};   // Earlier sample on top
            void'(exp_q.pop_front());
            void'(exp_q.pop_front());
            assert (tdata_o == expected) else report_mismatch("tdata_o", expected, tdata_o);
         end
         exp_last = ((word_count % WORDS_PER_PKT) == WORDS_PER_PKT - 1);
         assert (tlast_o == exp_last)
            else report_mismatch("tlast_o", 64'(exp_last), 64'(tlast_o));
         word_count++;
      end
   end

   initial begin
      #(CLK_PERIOD * (50 * TOTAL_SAMPLES + 1000));
      stop_with_failure("Watchdog expired before the tests finished");
   end

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin
      int          ovf_start;
      logic [15:0] off_i_bits;
      logic [15:0] off_q_bits;
      rst_n_i    = 1'b0;
      set_bus_i  = '0;
      adc_stb_i  = 1'b0;
      adc_data_i = '0;
      tready_i   = 1'b1;
      repeat (RESET_CYCLES) @(posedge radio_clk);
      #1 rst_n_i = 1'b1;
      next_cycle();
      assert (tvalid_o == 1'b0) else report_mismatch("tvalid_o", 64'd0, 64'(tvalid_o));
      assert (overflow_o == 1'b0) else report_mismatch("overflow_o", 64'd0, 64'(overflow_o));

      run_samples(P1_N, 1'b0, 1'b0);   // Default config passes samples through
      drain();

      off_i_bits = 16'(rand_bits(15)) | 16'h0001;   // Positive
      off_q_bits = ~16'(rand_bits(15));             // Negative
      write_setting(SR_OFFSET_I, {16'(rand_bits(16)), off_i_bits});
      write_setting(SR_OFFSET_Q, {16'(rand_bits(16)), off_q_bits});
      cfg_off_i = int'($signed(off_i_bits));
      cfg_off_q = int'($signed(off_q_bits));
      push_sample(32'h8000_7fff);        // Clamps at both ends
      run_samples(P2_N - 1, 1'b1, 1'b0);
      drain();

      for (int m = 0; m < 4; m++) begin
         write_setting(SR_IQ_MAPPING, {30'(rand_bits(30)), m[1:0]});
         write_setting(set_addr_t'(SET_RX_FE_BASE), rand_bits(32));   // Magnitude address is ignored
         cfg_swap = m[0];
         cfg_inv  = m[1];
         push_sample(32'h8000_8000);
         run_samples(P3_N - 1, 1'b1, 1'b0);
         drain();
      end

      toggle_ready = 1'b1;
      run_samples(P5_N, 1'b0, 1'b1);
      toggle_ready = 1'b0;
      next_cycle();
      tready_i = 1'b1;
      drain();
      assert (overflow_o == 1'b0) else report_mismatch("overflow_o", 64'd0, 64'(overflow_o));

      // Stall the output until the FIFO drops samples
      lossy     = 1'b1;
      ovf_start = word_count;
      next_cycle();
      tready_i = 1'b0;
      run_samples(P6_N, 1'b0, 1'b0);
      repeat (4) next_cycle();
      assert (overflow_o == 1'b1) else report_mismatch("overflow_o", 64'd1, 64'(overflow_o));
      tready_i = 1'b1;
      while (word_count < ovf_start + OVF_WORDS) next_cycle();
      repeat (20) next_cycle();
      assert (word_count == ovf_start + OVF_WORDS)
         else stop_with_failure("Too many words came out after the overflow");
      assert (overflow_o == 1'b1) else report_mismatch("overflow_o", 64'd1, 64'(overflow_o));
      exp_q.delete();                    // Dropped samples never arrive
      lossy = 1'b0;
      repeat (20) next_cycle();

      if (word_count == EXPECTED_WORDS) begin
         verdict_done = 1'b1;
         $display("RESULT: PASS");
         $finish;
      end else begin
         stop_with_failure("Total number of output words is wrong");
      end
   end

endmodule : tb_rx_radio

`default_nettype wire

/* sim.f */
src/radio_pkg.sv
src/rx_settings_regs.sv
src/rx_frontend.sv
src/sample_fifo.sv
src/rx_packetizer.sv
src/rx_radio_top.sv
testbench/tb_rx_radio_asserts.sv
testbench/tb_rx_radio.sv

/* Makefile */
SRCS := $(wildcard src/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_rx_radio: sim.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_rx_radio -f sim.f -o Vtb_rx_radio

run: obj_dir/Vtb_rx_radio
	@out="$$(./obj_dir/Vtb_rx_radio 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
